// ==== sbox.hex ====
// AES forward S-box, one byte per entry, row n holds inputs 16n to 16n+15
63 7c 77 7b f2 6b 6f c5 30 01 67 2b fe d7 ab 76
ca 82 c9 7d fa 59 47 f0 ad d4 a2 af 9c a4 72 c0
b7 fd 93 26 36 3f f7 cc 34 a5 e5 f1 71 d8 31 15
04 c7 23 c3 18 96 05 9a 07 12 80 e2 eb 27 b2 75
09 83 2c 1a 1b 6e 5a a0 52 3b d6 b3 29 e3 2f 84
53 d1 00 ed 20 fc b1 5b 6a cb be 39 4a 4c 58 cf
d0 ef aa fb 43 4d 33 85 45 f9 02 7f 50 3c 9f a8
51 a3 40 8f 92 9d 38 f5 bc b6 da 21 10 ff f3 d2
cd 0c 13 ec 5f 97 44 17 c4 a7 7e 3d 64 5d 19 73
60 81 4f dc 22 2a 90 88 46 ee b8 14 de 5e 0b db
e0 32 3a 0a 49 06 24 5c c2 d3 ac 62 91 95 e4 79
e7 c8 37 6d 8d d5 4e a9 6c 56 f4 ea 65 7a ae 08
ba 78 25 2e 1c a6 b4 c6 e8 dd 74 1f 4b bd 8b 8a
70 3e b5 66 48 03 f6 0e 61 35 57 b9 86 c1 1d 9e
e1 f8 98 11 69 d9 8e 94 9b 1e 87 e9 ce 55 28 df
8c a1 89 0d bf e6 42 68 41 99 2d 0f b0 54 bb 16

// ==== vlog.f ====
aes_pkg.sv
aes_sub_bytes.sv
aes_round.sv
aes_key_schedule.sv
aes_round_counter.sv
aes_control.sv
aes_core.sv
tb_aes_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AES-128 testbench with Verilator; exit status is the simulation result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_aes_core \
    -o tb_aes_core_sim

# Run from the project root so sbox.hex is found
./obj_dir/tb_aes_core_sim

// ==== tb_aes_core.sv ====
// Run from the project root so the DUT finds sbox.hex; covers four AES-128 known answers only
`timescale 1ns/1ps

module tb_aes_core;
    import aes_pkg::*;

    localparam int num_vectors = 4;
    localparam int ack_timeout = 20;
    localparam int release_timeout = 4;
    localparam int expected_latency = 10;

    typedef struct packed {
        aes_state_t block;
        aes_state_t key;
        aes_state_t expected;
    } vector_t;

    logic         clk;
    logic         reset;
    logic         req;
    aes_request_t request;
    logic         ack;
    aes_state_t   ciphertext;

    vector_t      vectors [num_vectors];
    string        test_names [num_vectors];
    logic [15:0]  lfsr_state;

    aes_core i_dut
    (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .request    (request),
        .ack        (ack),
        .ciphertext (ciphertext)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_equal(input string test_name, input aes_state_t expected,
                               input aes_state_t actual);
        if (expected !== actual)
        begin
            report_failure($sformatf("error %s: expected %0h, actual %0h",
                                     test_name, expected, actual));
        end
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic feedback;
        feedback = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], feedback};
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            value = (value << 1) | int'(lfsr_state[15]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Published AES-128 known answers
    task automatic load_vector_table();
        test_names[0] = "fips197_c1";
        vectors[0] = '{block:    128'h00112233445566778899aabbccddeeff,
                       key:      128'h000102030405060708090a0b0c0d0e0f,
                       expected: 128'h69c4e0d86a7b0430d8cdb78070b4c55a};
        test_names[1] = "fips197_b";
        vectors[1] = '{block:    128'h3243f6a8885a308d313198a2e0370734,
                       key:      128'h2b7e151628aed2a6abf7158809cf4f3c,
                       expected: 128'h3925841d02dc09fbdc118597196a0b32};
        test_names[2] = "sp800_38a_ecb1";
        vectors[2] = '{block:    128'h6bc1bee22e409f96e93d7e117393172a,
                       key:      128'h2b7e151628aed2a6abf7158809cf4f3c,
                       expected: 128'h3ad77bb40d7a3660a89ecaf32466ef97};
        test_names[3] = "all_zero";
        vectors[3] = '{block:    128'h0,
                       key:      128'h0,
                       expected: 128'h66e94bd4ef8a2c3b884cfa59ca342b2e};
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (10)
        begin
            @(posedge clk);
            #1;
            check_equal("ack during reset", 128'd0, 128'(ack));
        end
        reset = 1'b0;
        // Nothing may happen while req stays low
        repeat (5)
        begin
            @(posedge clk);
            #1;
            check_equal("ack idle after reset", 128'd0, 128'(ack));
        end
    endtask

    //////////////////////////////////////////////////
    // One full four-phase transfer
    //////////////////////////////////////////////////

    task automatic run_vector(input int row);
        string name;
        int    edges;
        int    extra;
        name = test_names[row];

        request.block = vectors[row].block;
        request.key = vectors[row].key;
        req = 1'b1;

        // Edge E samples req
        @(posedge clk);
        #1;
        check_equal({name, " ack at accept"}, 128'd0, 128'(ack));

        edges = 0;
        while (!ack && edges < ack_timeout)
        begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (!ack)
        begin
            report_failure($sformatf("%s: ack did not rise within %0d cycles",
                                     name, ack_timeout));
        end
        check_equal({name, " latency"}, 128'(expected_latency), 128'(edges));
        check_equal({name, " ciphertext"}, vectors[row].expected, ciphertext);

        // Hold req a random number of extra cycles as back-pressure
        draw_bits(3, extra);
        repeat (extra)
        begin
            @(posedge clk);
            #1;
            check_equal({name, " ack while held"}, 128'd1, 128'(ack));
            check_equal({name, " ciphertext while held"}, vectors[row].expected, ciphertext);
        end

        req = 1'b0;
        edges = 0;
        while (ack && edges < release_timeout)
        begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (ack)
        begin
            report_failure($sformatf("%s: ack still high %0d cycles after req fell",
                                     name, release_timeout));
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        req = 1'b0;
        request = '0;
        lfsr_state = 16'd16;

        load_vector_table();
        apply_reset();

        // Each next request goes out right after ack falls.
        for (int row = 0; row < num_vectors; row++)
        begin
            run_vector(row);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== aes_core.sv ====
// Iterative AES-128 encryptor, ack ten cycles after the request is sampled; no decryption
`timescale 1ns/1ps

module aes_core
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  aes_pkg::aes_request_t  request,
    output logic                  ack,
    output aes_pkg::aes_state_t    ciphertext
);
    import aes_pkg::*;

    logic         start;
    logic         advance;
    logic         last_round;
    round_index_t round_index;
    aes_state_t   round_key;

    aes_control i_control
    (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .last_round (last_round),
        .start      (start),
        .advance    (advance),
        .ack        (ack)
    );

    aes_round_counter i_round_counter
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .advance     (advance),
        .round_index (round_index),
        .last_round  (last_round)
    );

    aes_key_schedule i_key_schedule
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .advance     (advance),
        .key         (request.key),
        .round_index (round_index),
        .round_key   (round_key)
    );

    // Held state is the ciphertext once ack is up
    aes_round i_round
    (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .advance    (advance),
        .block      (request.block),
        .key        (request.key),
        .round_key  (round_key),
        .last_round (last_round),
        .state      (ciphertext)
    );

endmodule

// ==== aes_control.sv ====
// Four-phase req/ack; the requester holds the request stable while req is high, one block at a time
`timescale 1ns/1ps

module aes_control
(
    input  logic clk,
    input  logic reset,
    input  logic req,
    input  logic last_round,
    output logic start,
    output logic advance,
    output logic ack
);
    import aes_pkg::*;

    typedef enum logic [1:0]
    {
        st_idle,
        st_run,
        st_done
    } ctrl_state_t;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            st_idle:
            begin
                if (req)
                    state_d = st_run;
            end
            st_run:
            begin
                if (last_round)
                    state_d = st_done;
            end
            st_done:
            begin
                // Hold the result until the requester lets go
                if (!req)
                    state_d = st_idle;
            end
            default:
            begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state_q <= st_idle;
        else
            state_q <= state_d;
    end

    assign start = (state_q == st_idle) && req;
    assign advance = (state_q == st_run);
    assign ack = (state_q == st_done);

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (reset) !(start && advance))
    else $error("aes_control: start and advance together");

    // Exactly ten round cycles, then the result is acknowledged
    assert property (@(posedge clk) disable iff (reset)
        start |=> advance [*num_rounds] ##1 ack)
    else $error("aes_control: round sequence broken");

    assert property (@(posedge clk) disable iff (reset) $fell(ack) |-> !$past(req))
    else $error("aes_control: ack dropped while req was high");

endmodule

// ==== aes_round_counter.sv ====
// Counts rounds 1..10 of one block; the value after the last advance is past range and not used
`timescale 1ns/1ps

module aes_round_counter
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 advance,
    output aes_pkg::round_index_t round_index,
    output logic                 last_round
);
    import aes_pkg::*;

    round_index_t count_q;

    always_ff @(posedge clk)
    begin
        if (reset)
            count_q <= '0;
        else if (start)
            count_q <= round_index_t'(1);
        else if (advance)
            count_q <= count_q + round_index_t'(1);
    end

    assign round_index = count_q;
    assign last_round = (count_q == num_rounds);

    // Control must stop stepping once round 10 is done
    assert property (@(posedge clk) disable iff (reset)
        advance |-> (count_q != '0 && count_q <= num_rounds))
    else $error("aes_round_counter: advance with round index %0d", count_q);

endmodule

// ==== aes_key_schedule.sv ====
// On-the-fly AES-128 key expansion; round_index must match the round the datapath is applying
`timescale 1ns/1ps

module aes_key_schedule
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 advance,
    input  aes_pkg::aes_state_t   key,
    input  aes_pkg::round_index_t round_index,
    output aes_pkg::aes_state_t   round_key
);
    import aes_pkg::*;

    // Round key of the previous round, cipher key after start
    aes_state_t key_q;

    aes_word_t w0, w1, w2, w3;
    aes_word_t rot_word;
    aes_word_t sub_word;
    aes_word_t temp_word;
    aes_word_t n0, n1, n2, n3;

    assign {w0, w1, w2, w3} = key_q;

    //////////////////////////////////////////////////
    // g() on the last column
    //////////////////////////////////////////////////

    assign rot_word = {w3[23:0], w3[31:24]};

    aes_sub_bytes #(.payload_t(aes_word_t)) i_sub_word
    (
        .data_in  (rot_word),
        .data_out (sub_word)
    );

    assign temp_word = sub_word ^ {rcon_for_round(round_index), 24'h000000};

    // Each new column chains on the one before it
    assign n0 = w0 ^ temp_word;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    assign round_key = {n0, n1, n2, n3};

    always_ff @(posedge clk)
    begin
        if (reset)
            key_q <= '0;
        else if (start)
            key_q <= key;
        else if (advance)
            key_q <= round_key;
    end

endmodule

// ==== aes_round.sv ====
// One AES round per advance; state is only meaningful as ciphertext once round 10 has been applied
`timescale 1ns/1ps

module aes_round
(
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               advance,
    input  aes_pkg::aes_state_t block,
    input  aes_pkg::aes_state_t key,
    input  aes_pkg::aes_state_t round_key,
    input  logic               last_round,
    output aes_pkg::aes_state_t state
);
    import aes_pkg::*;

    // Byte (column c, row r) of the state sits at bit block_width-1-8*(4c+r)
    function automatic aes_state_t shift_rows(input aes_state_t s);
        aes_state_t shifted;
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                // Row r rotates left by r columns
                shifted[block_width-1-8*(4*c+r) -: 8] =
                    s[block_width-1-8*(4*((c+r)%4)+r) -: 8];
            end
        end
        return shifted;
    endfunction

    // 2a ^ 3b ^ c ^ d rewritten as a ^ sum ^ xtime(a ^ b)
    function automatic aes_word_t mix_column(input aes_word_t col);
        logic [7:0] a0, a1, a2, a3;
        logic [7:0] col_sum;
        {a0, a1, a2, a3} = col;
        col_sum = a0 ^ a1 ^ a2 ^ a3;
        return {a0 ^ col_sum ^ xtime(a0 ^ a1),
                a1 ^ col_sum ^ xtime(a1 ^ a2),
                a2 ^ col_sum ^ xtime(a2 ^ a3),
                a3 ^ col_sum ^ xtime(a3 ^ a0)};
    endfunction

    function automatic aes_state_t mix_columns(input aes_state_t s);
        aes_state_t mixed;
        for (int c = 0; c < 4; c++)
        begin
            mixed[block_width-1-word_width*c -: word_width] =
                mix_column(s[block_width-1-word_width*c -: word_width]);
        end
        return mixed;
    endfunction

    //////////////////////////////////////////////////
    // Round datapath
    //////////////////////////////////////////////////

    aes_state_t state_q;
    aes_state_t subbed;
    aes_state_t shifted;
    aes_state_t round_out;

    aes_sub_bytes #(.payload_t(aes_state_t)) i_sub_state
    (
        .data_in  (state_q),
        .data_out (subbed)
    );

    assign shifted = shift_rows(subbed);

    // Final round skips mix-columns
    assign round_out = (last_round ? shifted : mix_columns(shifted)) ^ round_key;

    always_ff @(posedge clk)
    begin
        if (reset)
            state_q <= '0;
        else if (start)
            state_q <= block ^ key;
        else if (advance)
            state_q <= round_out;
    end

    assign state = state_q;

endmodule

// ==== aes_sub_bytes.sv ====
// Combinational S-box lookup; payload width must be a whole number of bytes, sbox.hex must be readable
`timescale 1ns/1ps

module aes_sub_bytes
#(
    parameter type payload_t = aes_pkg::aes_word_t
)
(
    input  payload_t data_in,
    output payload_t data_out
);
    import aes_pkg::*;

    localparam int num_bytes = $bits(payload_t) / 8;

    logic [7:0] sbox_table [0:255];

    initial
    begin
        $readmemh(sbox_file, sbox_table);
    end

    initial
    begin
        assert ($bits(payload_t) % 8 == 0)
        else $fatal(1, "aes_sub_bytes: payload width %0d is not a byte multiple",
                    $bits(payload_t));
    end

    //////////////////////////////////////////////////
    // One lookup per byte lane
    //////////////////////////////////////////////////

    always_comb
    begin
        data_out = data_in;
        for (int i = 0; i < num_bytes; i++)
        begin
            data_out[8*i +: 8] = sbox_table[data_in[8*i +: 8]];
        end
    end

endmodule

// ==== aes_pkg.sv ====
// AES-128 only (Nk = 4, ten rounds); block byte 0 lives in bits [127:120], as FIPS-197 lists it
package aes_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    localparam int block_width = 128;
    localparam int word_width = 32;

    typedef logic [3:0] round_index_t;
    typedef logic [word_width-1:0] aes_word_t;

    // Column 0 in the top 32 bits, row 0 at the top of each column
    typedef logic [block_width-1:0] aes_state_t;

    localparam round_index_t num_rounds = 4'd10;

    // Forward S-box, 256 bytes, read at elaboration
    localparam string sbox_file = "sbox.hex";

    typedef struct packed {
        aes_state_t block;
        aes_state_t key;
    } aes_request_t;

    //////////////////////////////////////////////////
    // GF(2^8) helpers
    //////////////////////////////////////////////////

    // Multiply by x, reduce by x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] value);
        logic [7:0] shifted;
        shifted = {value[6:0], 1'b0};
        return value[7] ? (shifted ^ 8'h1b) : shifted;
    endfunction

    // Round constant of the key expansion, rounds 1 to 10
    function automatic logic [7:0] rcon_for_round(input round_index_t round_index);
        logic [7:0] rcon;
        case (round_index)
            4'd1:    rcon = 8'h01;
            4'd2:    rcon = 8'h02;
            4'd3:    rcon = 8'h04;
            4'd4:    rcon = 8'h08;
            4'd5:    rcon = 8'h10;
            4'd6:    rcon = 8'h20;
            4'd7:    rcon = 8'h40;
            4'd8:    rcon = 8'h80;
            4'd9:    rcon = 8'h1b;
            4'd10:   rcon = 8'h36;
            default: rcon = 8'h00;
        endcase
        return rcon;
    endfunction

endpackage
